// File: build.f
+incdir+.
lz77_pkg.sv
lz77_detect_one.sv
lz77_ctrl.sv
lz77_buffer.sv
lz77_match.sv
lz77_top.sv
tb_lz77_top.sv

// File: Bender.yml
package:
  name: lz77_core

export_include_dirs:
  - .

sources:
  - lz77_pkg.sv
  - lz77_detect_one.sv
  - lz77_ctrl.sv
  - lz77_buffer.sv
  - lz77_match.sv
  - lz77_top.sv
  - target: test
    files:
      - tb_lz77_top.sv

// File: tb_lz77_top.sv
/*
  testbench for the lz77 compressor core
  fifo model, greedy reference parser, job table and token checks
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module tb_lz77_top;

  localparam int NJOB = 12;

  logic                 clk;
  logic                 rstn;
  logic                 start_i;
  lz77_pkg::blk_t       cfg_len_i;
  logic                 rd_o;
  lz77_pkg::dat_t       rd_dat_i;
  logic                 val_o;
  logic                 flg_lit_o;
  lz77_pkg::dat_t       dat_lit_o;
  lz77_pkg::len_t       dat_len_o;
  lz77_pkg::dst_t       dat_dst_o;
  logic                 flg_lst_o;
  logic                 done_o;

  // table entry is {length, kind, seed, expected token count or ff}
  logic [31:0]          job_tab [NJOB];
  logic [7:0]           fifo_mem [256];
  logic                 exp_lit [256];
  int                   exp_len [256];
  int                   exp_dst [256];
  logic [7:0]           exp_dat [256];
  int                   exp_n;
  int                   job_len;
  int                   rd_cnt;
  int                   tok_idx;
  int                   len_sum;
  logic                 job_active;
  logic                 done_seen;
  logic                 jobs_loaded;
  logic [31:0]          lcg_state;
  int                   chk_cnt;
  int                   err_cnt;

  lz77_top u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_len_i (cfg_len_i),
    .rd_o      (rd_o),
    .rd_dat_i  (rd_dat_i),
    .val_o     (val_o),
    .flg_lit_o (flg_lit_o),
    .dat_lit_o (dat_lit_o),
    .dat_len_o (dat_len_o),
    .dat_dst_o (dat_dst_o),
    .flg_lst_o (flg_lst_o),
    .done_o    (done_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic load_jobs();
    job_tab[0]  = {8'd20,  8'd0, 8'h40, 8'd20};
    job_tab[1]  = {8'd24,  8'd1, 8'h61, 8'd7};
    // same block again, window must start empty
    job_tab[2]  = {8'd24,  8'd1, 8'h61, 8'd7};
    job_tab[3]  = {8'd16,  8'd2, 8'h20, 8'd10};
    job_tab[4]  = {8'd36,  8'd3, 8'h00, 8'd36};
    job_tab[5]  = {8'd1,   8'd5, 8'h00, 8'd1};
    job_tab[6]  = {8'd2,   8'd1, 8'h61, 8'd2};
    job_tab[7]  = {8'd3,   8'd1, 8'h61, 8'd3};
    job_tab[8]  = {8'd5,   8'd1, 8'h61, 8'd5};
    job_tab[9]  = {8'd255, 8'd4, 8'h00, 8'hff};
    job_tab[10] = {8'd60,  8'd5, 8'h00, 8'hff};
    job_tab[11] = {8'd100, 8'd4, 8'h00, 8'hff};
  endtask

  // kinds: 0 distinct, 1 4-byte phrase, 2 phrase plus unique byte,
  // 3 phrase beyond the window, 4 random small alphabet, 5 random
  task automatic fill_block(input int len, input int kind, input logic [7:0] seed);
    for (int i = 0; i < len; i++) begin
      lcg_state = lcg_next(lcg_state);
      case (kind)
        0: fifo_mem[i] = seed + 8'(i);
        1: fifo_mem[i] = seed + 8'(i % 4);
        2: fifo_mem[i] = (i % 4 < 3) ? seed + 8'h80 + 8'(i % 4) : seed + 8'(i);
        3: begin
          if (i < 4 || (i >= 24 && i < 28)) begin
            fifo_mem[i] = 8'ha0 + 8'(i % 4);
          end else if (i >= 30 && i < 32) begin
            fifo_mem[i] = 8'h10 + 8'(i - 10);
          end else begin
            fifo_mem[i] = 8'h10 + 8'(i);
          end
        end
        4: fifo_mem[i] = 8'h41 + 8'(lcg_state[17:16]);
        default: fifo_mem[i] = lcg_state[23:16];
      endcase
    end
  endtask

  // greedy parse, longest match first, smallest distance on ties
  task automatic build_expected(input int len);
    int pos;
    int lmax;
    int wlen;
    int l;
    int best_len;
    int best_d;
    exp_n = 0;
    pos = 0;
    while (pos < len) begin
      lmax = (len - pos < `LZ77_LEN_MAX) ? len - pos : `LZ77_LEN_MAX;
      wlen = (pos < `LZ77_WIN_SIZE) ? pos : `LZ77_WIN_SIZE;
      best_len = 0;
      best_d = 0;
      for (int d = 1; d <= wlen; d++) begin
        l = 0;
        while (l < lmax && l < d && fifo_mem[pos + l] == fifo_mem[pos + l - d]) begin
          l++;
        end
        if (l > best_len) begin
          best_len = l;
          best_d = d;
        end
      end
      exp_dat[exp_n] = fifo_mem[pos];
      exp_lit[exp_n] = (best_len < `LZ77_LEN_MIN);
      exp_len[exp_n] = exp_lit[exp_n] ? 1 : best_len;
      exp_dst[exp_n] = exp_lit[exp_n] ? 1 : best_d;
      pos += exp_len[exp_n];
      exp_n++;
    end
  endtask

  // ------------------------------------------------------------
  // fifo model, byte one cycle after the read
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (rd_o) begin
      if (rd_cnt < job_len) begin
        rd_dat_i <= fifo_mem[rd_cnt];
      end else begin
        err_cnt++;
        $display("ERROR t=%0t read past the end of the block", $time);
        rd_dat_i <= '0;
      end
      rd_cnt = rd_cnt + 1;
    end
  end

  // token monitor
  always @(negedge clk) begin
    if (rstn && val_o) begin
      if (!job_active || tok_idx >= exp_n) begin
        err_cnt++;
        $display("ERROR t=%0t token seen with none expected", $time);
      end else begin
        check_val("flg_lit_o", flg_lit_o, exp_lit[tok_idx]);
        check_val("dat_len_o", dat_len_o, exp_len[tok_idx]);
        check_val("dat_dst_o", dat_dst_o, exp_dst[tok_idx]);
        if (exp_lit[tok_idx]) begin
          check_val("dat_lit_o", dat_lit_o, exp_dat[tok_idx]);
        end
        check_val("flg_lst_o", flg_lst_o, tok_idx == exp_n - 1);
        check_val("done_o", done_o, tok_idx == exp_n - 1);
      end
      len_sum += dat_len_o;
      tok_idx++;
      if (done_o) begin
        done_seen = 1'b1;
      end
    end else if (rstn) begin
      check_val("flg_lit_o", flg_lit_o, 0);
      check_val("dat_lit_o", dat_lit_o, 0);
      check_val("dat_len_o", dat_len_o, 0);
      check_val("dat_dst_o", dat_dst_o, 0);
      check_val("flg_lst_o", flg_lst_o, 0);
      check_val("done_o", done_o, 0);
    end
  end

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------
  initial begin
    longint total;
    total = 0;
    wait (jobs_loaded);
    for (int j = 0; j < NJOB; j++) begin
      total += job_tab[j][31:24];
    end
    #((total * 40 + 200) * 100);
    $display("ERROR watchdog expired before all jobs finished");
    $display("checks %0d errors %0d", chk_cnt, err_cnt + 1);
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    int wait_cnt;
    rstn = 1'b0;
    start_i = 1'b0;
    cfg_len_i = '0;
    rd_dat_i = '0;
    job_len = 0;
    rd_cnt = 0;
    tok_idx = 0;
    len_sum = 0;
    exp_n = 0;
    job_active = 1'b0;
    done_seen = 1'b0;
    chk_cnt = 0;
    err_cnt = 0;
    lcg_state = 32'h11e2;
    load_jobs();
    jobs_loaded = 1'b1;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_val("rd_o", rd_o, 0);
    check_val("val_o", val_o, 0);
    check_val("flg_lst_o", flg_lst_o, 0);
    check_val("done_o", done_o, 0);
    @(posedge clk);
    rstn <= 1'b1;
    repeat (2) @(posedge clk);

    for (int j = 0; j < NJOB; j++) begin
      job_len = job_tab[j][31:24];
      fill_block(job_len, job_tab[j][23:16], job_tab[j][15:8]);
      build_expected(job_len);
      if (job_tab[j][7:0] != 8'hff) begin
        check_val("expected token count", exp_n, job_tab[j][7:0]);
      end
      rd_cnt = 0;
      tok_idx = 0;
      len_sum = 0;
      done_seen = 1'b0;
      job_active = 1'b1;
      start_i <= 1'b1;
      cfg_len_i <= lz77_pkg::blk_t'(job_len);
      @(posedge clk);
      start_i <= 1'b0;
      wait_cnt = 0;
      while (!done_seen && wait_cnt < job_len * 40 + 100) begin
        @(posedge clk);
        wait_cnt++;
      end
      if (!done_seen) begin
        err_cnt++;
        $display("ERROR job %0d never raised done_o", j);
      end
      repeat (2) @(posedge clk);
      job_active = 1'b0;
      check_val("token count", tok_idx, exp_n);
      check_val("read count", rd_cnt, job_len);
      check_val("token length sum", len_sum, job_len);
    end

    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: lz77_top.sv
/*
  lz77 compressor core top level
  controller, window/lookahead buffer and matcher
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module lz77_top (
  input  logic           clk,
  input  logic           rstn,
  input  logic           start_i,
  input  lz77_pkg::blk_t cfg_len_i,
  output logic           rd_o,
  input  lz77_pkg::dat_t rd_dat_i,
  output logic           val_o,
  output logic           flg_lit_o,
  output lz77_pkg::dat_t dat_lit_o,
  output lz77_pkg::len_t dat_len_o,
  output lz77_pkg::dst_t dat_dst_o,
  output logic           flg_lst_o,
  output logic           done_o
);

  logic                                rd_o_d;
  logic                                upt_shift;
  lz77_pkg::len_t                      shift_len;
  logic                                sch_start;
  lz77_pkg::len_t                      sch_cnt;
  logic                                sch_end;
  lz77_pkg::len_t                      tok_len;
  logic                                tok_emit;
  logic                                tok_last;
  lz77_pkg::dat_t [`LZ77_WIN_SIZE-1:0] win_dat;
  lz77_pkg::dst_t                      win_len;
  lz77_pkg::dat_t [`LZ77_LEN_MAX-1:0]  inp_dat;
  lz77_pkg::len_t                      inp_len;

  // fifo data is valid one cycle after the read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_o_d <= 1'b0;
    end else begin
      rd_o_d <= rd_o;
    end
  end

  lz77_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .sch_end_i   (sch_end),
    .tok_len_i   (tok_len),
    .rd_o        (rd_o),
    .upt_shift_o (upt_shift),
    .shift_len_o (shift_len),
    .sch_start_o (sch_start),
    .sch_cnt_o   (sch_cnt),
    .tok_emit_o  (tok_emit),
    .tok_last_o  (tok_last)
  );

  lz77_buffer u_buffer (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .rd_o_d      (rd_o_d),
    .rd_dat_i    (rd_dat_i),
    .upt_shift_i (upt_shift),
    .shift_len_i (shift_len),
    .win_dat_o   (win_dat),
    .win_len_o   (win_len),
    .inp_dat_o   (inp_dat),
    .inp_len_o   (inp_len)
  );

  lz77_match u_match (
    .clk         (clk),
    .rstn        (rstn),
    .win_dat_i   (win_dat),
    .win_len_i   (win_len),
    .inp_dat_i   (inp_dat),
    .inp_len_i   (inp_len),
    .sch_start_i (sch_start),
    .sch_cnt_i   (sch_cnt),
    .tok_emit_i  (tok_emit),
    .tok_last_i  (tok_last),
    .sch_end_o   (sch_end),
    .tok_len_o   (tok_len),
    .val_o       (val_o),
    .flg_lit_o   (flg_lit_o),
    .dat_lit_o   (dat_lit_o),
    .dat_len_o   (dat_len_o),
    .dat_dst_o   (dat_dst_o),
    .flg_lst_o   (flg_lst_o),
    .done_o      (done_o)
  );

endmodule

// File: lz77_match.sv
/*
  lz77 matcher
  narrowing match flags, best length and distance, literal decision
  and registered token outputs
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module lz77_match (
  input  logic                                clk,
  input  logic                                rstn,
  input  lz77_pkg::dat_t [`LZ77_WIN_SIZE-1:0] win_dat_i,
  input  lz77_pkg::dst_t                      win_len_i,
  input  lz77_pkg::dat_t [`LZ77_LEN_MAX-1:0]  inp_dat_i,
  input  lz77_pkg::len_t                      inp_len_i,
  input  logic                                sch_start_i,
  input  lz77_pkg::len_t                      sch_cnt_i,
  input  logic                                tok_emit_i,
  input  logic                                tok_last_i,
  output logic                                sch_end_o,
  output lz77_pkg::len_t                      tok_len_o,
  output logic                                val_o,
  output logic                                flg_lit_o,
  output lz77_pkg::dat_t                      dat_lit_o,
  output lz77_pkg::len_t                      dat_len_o,
  output lz77_pkg::dst_t                      dat_dst_o,
  output logic                                flg_lst_o,
  output logic                                done_o
);

  // flag i stands for distance i+1
  logic [`LZ77_WIN_SIZE-1:0] flg_r;
  logic [`LZ77_WIN_SIZE-1:0] flg_cur;
  logic [`LZ77_WIN_SIZE-1:0] flg_nxt;
  lz77_pkg::dst_t            pos_w;
  lz77_pkg::len_t            stp_len;
  lz77_pkg::len_t            bst_len_r;
  lz77_pkg::dst_t            bst_dst_r;
  lz77_pkg::len_t            bst_len_c;
  lz77_pkg::dst_t            bst_dst_c;
  lz77_pkg::len_t            nxt_len;
  lz77_pkg::dst_t            nxt_dst;
  logic                      hit;
  logic                      take;
  logic                      lst_r;

  // ------------------------------------------------------------
  // flag narrowing
  // ------------------------------------------------------------
  assign flg_cur = sch_start_i ? '1 : flg_r;

  // drop distances that are too short, outside the window or mismatched
  always_comb begin
    for (int i = 0; i < `LZ77_WIN_SIZE; i++) begin
      flg_nxt[i] = 1'b0;
      if (flg_cur[i] && (i >= int'(sch_cnt_i)) && (i < int'(win_len_i))) begin
        flg_nxt[i] = (win_dat_i[i - int'(sch_cnt_i)] == inp_dat_i[sch_cnt_i]);
      end
    end
  end

  lz77_detect_one u_detect_one (
    .dat_i (flg_nxt),
    .pos_o (pos_w)
  );

  // ------------------------------------------------------------
  // best length and distance
  // ------------------------------------------------------------
  assign stp_len   = sch_cnt_i + 1'b1;
  assign hit       = |flg_nxt;
  assign take      = hit && (stp_len >= lz77_pkg::len_t'(`LZ77_LEN_MIN));
  // literal until a long enough match shows up
  assign bst_len_c = sch_start_i ? lz77_pkg::len_t'(1) : bst_len_r;
  assign bst_dst_c = sch_start_i ? lz77_pkg::dst_t'(1) : bst_dst_r;
  assign nxt_len   = take ? stp_len : bst_len_c;
  assign nxt_dst   = take ? pos_w : bst_dst_c;

  // early exit on empty flags, else stop at the lookahead end
  assign sch_end_o = !hit || (stp_len >= inp_len_i);
  assign tok_len_o = nxt_len;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flg_r     <= '0;
      bst_len_r <= '0;
      bst_dst_r <= '0;
    end else begin
      flg_r     <= flg_nxt;
      bst_len_r <= nxt_len;
      bst_dst_r <= nxt_dst;
    end
  end

  // ------------------------------------------------------------
  // token outputs
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_o     <= 1'b0;
      flg_lit_o <= 1'b0;
      dat_lit_o <= '0;
      dat_len_o <= '0;
      dat_dst_o <= '0;
      lst_r     <= 1'b0;
    end else begin
      val_o     <= tok_emit_i;
      flg_lit_o <= tok_emit_i && (nxt_len < lz77_pkg::len_t'(`LZ77_LEN_MIN));
      dat_lit_o <= tok_emit_i ? inp_dat_i[0] : '0;
      dat_len_o <= tok_emit_i ? nxt_len : '0;
      dat_dst_o <= tok_emit_i ? nxt_dst : '0;
      lst_r     <= tok_last_i;
    end
  end

  assign flg_lst_o = lst_r;
  assign done_o    = lst_r;

  a_tok_len_range: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> (dat_len_o >= lz77_pkg::len_t'(1)) &&
              (dat_len_o <= lz77_pkg::len_t'(`LZ77_LEN_MAX)) && (dat_dst_o != '0));

endmodule

// File: lz77_buffer.sv
/*
  lz77 window and lookahead buffers
  byte shift registers, fifo append and shift by token length
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module lz77_buffer (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                start_i,
  input  logic                                rd_o_d,
  input  lz77_pkg::dat_t                      rd_dat_i,
  input  logic                                upt_shift_i,
  input  lz77_pkg::len_t                      shift_len_i,
  output lz77_pkg::dat_t [`LZ77_WIN_SIZE-1:0] win_dat_o,
  output lz77_pkg::dst_t                      win_len_o,
  output lz77_pkg::dat_t [`LZ77_LEN_MAX-1:0]  inp_dat_o,
  output lz77_pkg::len_t                      inp_len_o
);

  localparam int DST_WD = $bits(lz77_pkg::dst_t);

  // win_r[0] is the most recent byte, distance 1
  lz77_pkg::dat_t [`LZ77_WIN_SIZE-1:0] win_r;
  lz77_pkg::dat_t [`LZ77_WIN_SIZE-1:0] win_sft;
  // inp_r[0] is the current position
  lz77_pkg::dat_t [`LZ77_LEN_MAX-1:0]  inp_r;
  lz77_pkg::dat_t [`LZ77_LEN_MAX-1:0]  inp_sft;
  lz77_pkg::dst_t                      win_len_r;
  lz77_pkg::len_t                      inp_len_r;
  logic [DST_WD:0]                     win_sum;

  // ------------------------------------------------------------
  // shift network
  // ------------------------------------------------------------
  always_comb begin
    for (int j = 0; j < `LZ77_WIN_SIZE; j++) begin
      if (j < int'(shift_len_i)) begin
        win_sft[j] = inp_r[int'(shift_len_i) - 1 - j];
      end else begin
        win_sft[j] = win_r[j - int'(shift_len_i)];
      end
    end
    for (int j = 0; j < `LZ77_LEN_MAX; j++) begin
      if (j + int'(shift_len_i) < `LZ77_LEN_MAX) begin
        inp_sft[j] = inp_r[j + int'(shift_len_i)];
      end else begin
        inp_sft[j] = '0;
      end
    end
  end

  assign win_sum = (DST_WD+1)'(win_len_r) + (DST_WD+1)'(shift_len_i);

  // ------------------------------------------------------------
  // byte storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (start_i) begin
      win_r <= '0;
      inp_r <= '0;
    end else if (upt_shift_i) begin
      win_r <= win_sft;
      inp_r <= inp_sft;
    end else if (rd_o_d) begin
      inp_r[inp_len_r] <= rd_dat_i;
    end
  end

  // fill levels
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      win_len_r <= '0;
      inp_len_r <= '0;
    end else if (start_i) begin
      win_len_r <= '0;
      inp_len_r <= '0;
    end else if (upt_shift_i) begin
      // window saturates at its depth
      if (win_sum > (DST_WD+1)'(`LZ77_WIN_SIZE)) begin
        win_len_r <= lz77_pkg::dst_t'(`LZ77_WIN_SIZE);
      end else begin
        win_len_r <= win_sum[DST_WD-1:0];
      end
      inp_len_r <= inp_len_r - shift_len_i;
    end else if (rd_o_d) begin
      inp_len_r <= inp_len_r + 1'b1;
    end
  end

  assign win_dat_o = win_r;
  assign win_len_o = win_len_r;
  assign inp_dat_o = inp_r;
  assign inp_len_o = inp_len_r;

  // controller never fetches into a full lookahead
  a_inp_len_max: assert property (@(posedge clk) disable iff (!rstn)
    (inp_len_o <= lz77_pkg::len_t'(`LZ77_LEN_MAX)) &&
    (!rd_o_d || (inp_len_o < lz77_pkg::len_t'(`LZ77_LEN_MAX))));

endmodule

// File: lz77_ctrl.sv
/*
  lz77 controller
  idle/update/search FSM, read strobes, block and search counters
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module lz77_ctrl (
  input  logic           clk,
  input  logic           rstn,
  input  logic           start_i,
  input  lz77_pkg::blk_t cfg_len_i,
  input  logic           sch_end_i,
  input  lz77_pkg::len_t tok_len_i,
  output logic           rd_o,
  output logic           upt_shift_o,
  output lz77_pkg::len_t shift_len_o,
  output logic           sch_start_o,
  output lz77_pkg::len_t sch_cnt_o,
  output logic           tok_emit_o,
  output logic           tok_last_o
);

  lz77_pkg::lz77_state_e state_r;
  // bytes still to fetch from the fifo
  lz77_pkg::blk_t        rd_left_r;
  // bytes still to encode
  lz77_pkg::blk_t        enc_left_r;
  // lookahead fill after the pending shift
  lz77_pkg::len_t        fill_r;
  lz77_pkg::len_t        prev_len_r;
  lz77_pkg::len_t        sch_cnt_r;
  logic                  upt_fst_r;
  logic                  upt_gap_r;

  // ------------------------------------------------------------
  // strobes
  // ------------------------------------------------------------
  assign rd_o = (state_r == lz77_pkg::ST_UPT) &&
                (fill_r < lz77_pkg::len_t'(`LZ77_LEN_MAX)) &&
                (rd_left_r != '0);

  // shift by the previous token in the first update cycle
  assign upt_shift_o = (state_r == lz77_pkg::ST_UPT) && upt_fst_r;
  assign shift_len_o = prev_len_r;

  assign sch_start_o = (state_r == lz77_pkg::ST_SCH) && (sch_cnt_r == '0);
  assign sch_cnt_o   = sch_cnt_r;

  assign tok_emit_o = (state_r == lz77_pkg::ST_SCH) && sch_end_i;
  assign tok_last_o = tok_emit_o && (enc_left_r == lz77_pkg::blk_t'(tok_len_i));

  // ------------------------------------------------------------
  // fsm and counters
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r    <= lz77_pkg::ST_IDLE;
      rd_left_r  <= '0;
      enc_left_r <= '0;
      fill_r     <= '0;
      prev_len_r <= '0;
      sch_cnt_r  <= '0;
      upt_fst_r  <= 1'b0;
      upt_gap_r  <= 1'b0;
    end else begin
      case (state_r)
        lz77_pkg::ST_IDLE: begin
          if (start_i) begin
            state_r    <= lz77_pkg::ST_UPT;
            rd_left_r  <= cfg_len_i;
            enc_left_r <= cfg_len_i;
            fill_r     <= '0;
            prev_len_r <= '0;
            upt_fst_r  <= 1'b1;
            upt_gap_r  <= 1'b0;
          end
        end
        lz77_pkg::ST_UPT: begin
          upt_fst_r <= 1'b0;
          // reads first, then two cycles for the last byte to land
          if (rd_o) begin
            rd_left_r <= rd_left_r - 1'b1;
            fill_r    <= fill_r + 1'b1;
          end else if (upt_gap_r) begin
            upt_gap_r <= 1'b0;
            state_r   <= lz77_pkg::ST_SCH;
          end else begin
            upt_gap_r <= 1'b1;
          end
        end
        lz77_pkg::ST_SCH: begin
          if (sch_end_i) begin
            sch_cnt_r  <= '0;
            enc_left_r <= enc_left_r - lz77_pkg::blk_t'(tok_len_i);
            fill_r     <= fill_r - tok_len_i;
            prev_len_r <= tok_len_i;
            upt_fst_r  <= 1'b1;
            state_r    <= tok_last_o ? lz77_pkg::ST_IDLE : lz77_pkg::ST_UPT;
          end else begin
            sch_cnt_r <= sch_cnt_r + 1'b1;
          end
        end
        default: state_r <= lz77_pkg::ST_IDLE;
      endcase
    end
  end

  // search only runs once no further fifo read is pending
  a_no_rd_in_sch: assert property (@(posedge clk) disable iff (!rstn)
    (state_r == lz77_pkg::ST_SCH) |->
      ((rd_left_r == '0) || (fill_r == lz77_pkg::len_t'(`LZ77_LEN_MAX))));

endmodule

// File: lz77_detect_one.sv
/*
  lz77 distance encoder
  position of the lowest set match flag, plus one
*/

`timescale 1ns/1ps
`include "lz77_cfg.svh"

module lz77_detect_one (
  input  logic [`LZ77_WIN_SIZE-1:0] dat_i,
  output lz77_pkg::dst_t            pos_o
);

  // scan from the top so the lowest set flag wins
  always_comb begin
    pos_o = '0;
    for (int i = `LZ77_WIN_SIZE - 1; i >= 0; i--) begin
      if (dat_i[i]) begin
        pos_o = lz77_pkg::dst_t'(i + 1);
      end
    end
  end

endmodule

// File: lz77_pkg.sv
/*
  lz77 shared types
  controller state enum, byte, length, distance and count types
*/

`include "lz77_cfg.svh"

package lz77_pkg;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_UPT  = 2'd1,
    ST_SCH  = 2'd2
  } lz77_state_e;

  typedef logic [`LZ77_DAT_WD-1:0] dat_t;
  // 0 .. LEN_MAX
  typedef logic [$clog2(`LZ77_LEN_MAX+1)-1:0] len_t;
  // 0 .. WIN_SIZE
  typedef logic [$clog2(`LZ77_WIN_SIZE+1)-1:0] dst_t;
  typedef logic [`LZ77_BLK_WD-1:0] blk_t;

endpackage

// File: lz77_cfg.svh
/*
  lz77 core configuration macros
  byte width, window depth, match length limits and block counter width
*/

`ifndef LZ77_CFG_SVH
`define LZ77_CFG_SVH

// one input byte
`define LZ77_DAT_WD    8

// sliding window depth in bytes
`define LZ77_WIN_SIZE  16

// longest match, also the lookahead depth
`define LZ77_LEN_MAX   8

// shortest match sent as a length/distance pair
`define LZ77_LEN_MIN   3

// block length and byte counters, so at most 255 bytes per block
`define LZ77_BLK_WD    8

`endif
